/* source/conv_params.svh */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// square array, rows are input channels and columns output channels
`define CONV_ARRAY_DIM 4

`define CONV_IFMAP_W 16
`define CONV_WEIGHT_W 16

// output sums and output words share one width
`define CONV_OFMAP_W 32

// result vectors the drain can hold
`define CONV_FIFO_DEPTH 4

`endif

/* source/conv_pkg.sv */
`include "conv_params.svh"

package conv_pkg;

  typedef logic signed [`CONV_IFMAP_W-1:0]  ifmap_t;
  typedef logic signed [`CONV_WEIGHT_W-1:0] weight_t;
  typedef logic signed [`CONV_OFMAP_W-1:0]  ofmap_t;

  typedef ifmap_t [`CONV_ARRAY_DIM-1:0] ifmap_vec_t;  // lane = input channel
  typedef ofmap_t [`CONV_ARRAY_DIM-1:0] ofmap_vec_t;  // lane = output channel

  typedef enum logic [1:0] {
    w_empty,
    w_loading,
    w_ready
  } wload_state_e;

endpackage

/* source/ifmap_packer.sv */
`include "conv_params.svh"

module ifmap_packer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  conv_pkg::ifmap_t     ifmap_dat,
  input  logic                 ifmap_vld,
  output logic                 ifmap_rdy,
  input  logic                 weights_loaded,
  input  logic                 credit_ok,
  output logic                 issue,
  output conv_pkg::ifmap_vec_t issue_vec
);

  localparam int D = `CONV_ARRAY_DIM;

  logic [$clog2(D)-1:0] lane;
  logic                 accept;

  assign ifmap_rdy = weights_loaded & credit_ok;
  assign accept    = ifmap_vld & ifmap_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane  <= '0;
      issue <= 1'b0;
    end else begin
      issue <= accept && (lane == D - 1);  // vector complete
      if (accept)
        lane <= (lane == D - 1) ? '0 : lane + 1'b1;
    end
  end

  // lanes fill in place, whole vector stays put through the issue cycle
  always_ff @(posedge clk) begin
    if (accept)
      issue_vec[lane] <= ifmap_dat;
  end

  // weight set still in place when the vector enters the array
  a_issue_loaded: assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> weights_loaded);

endmodule

/* source/weight_loader.sv */
`include "conv_params.svh"

module weight_loader (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  conv_pkg::weight_t                       weights_dat,
  input  logic                                    weights_vld,
  output logic                                    weights_rdy,
  input  logic                                    array_busy,
  output logic                                    row_shift,
  output conv_pkg::weight_t [`CONV_ARRAY_DIM-1:0] row_vec,
  output logic                                    weights_loaded
);

  localparam int D = `CONV_ARRAY_DIM;

  conv_pkg::wload_state_e state;
  logic [$clog2(D)-1:0]   col;  // word within the row
  logic [$clog2(D)-1:0]   row;  // rows already taken
  logic                   accept;

  assign weights_rdy    = !array_busy;
  assign accept         = weights_vld & weights_rdy;
  assign weights_loaded = (state == conv_pkg::w_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= conv_pkg::w_empty;
      col       <= '0;
      row       <= '0;
      row_shift <= 1'b0;
    end else begin
      row_shift <= accept && (col == D - 1);
      if (accept) begin
        col <= (col == D - 1) ? '0 : col + 1'b1;
        if (col == D - 1)
          row <= (row == D - 1) ? '0 : row + 1'b1;
        if (col == D - 1 && row == D - 1)
          state <= conv_pkg::w_ready;
        else
          state <= conv_pkg::w_loading;  // first word drops weights_loaded
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      row_vec[col] <= weights_dat;
  end

  // weights never move under a vector still in the pipeline
  a_shift_idle: assert property (@(posedge clk) disable iff (!rst_n)
    row_shift |-> !array_busy);

endmodule

/* source/skew_delay.sv */
module skew_delay #(
  parameter int LANES   = 4,
  parameter int WIDTH   = 16,
  parameter bit REVERSE = 1'b0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [LANES-1:0][WIDTH-1:0] in_vec,
  output logic [LANES-1:0][WIDTH-1:0] out_vec
);

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    localparam int DLY = REVERSE ? LANES - 1 - k : k;

    if (DLY == 0) begin : g_thru
      assign out_vec[k] = in_vec[k];
    end else begin : g_dly
      logic [DLY-1:0][WIDTH-1:0] stage;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          stage <= '0;
        end else begin
          stage[0] <= in_vec[k];
          for (int s = 1; s < DLY; s++)
            stage[s] <= stage[s-1];
        end
      end

      assign out_vec[k] = stage[DLY-1];
    end
  end

endmodule

/* source/mac_pe.sv */
module mac_pe (
  input  logic              clk,
  input  logic              rst_n,
  input  conv_pkg::weight_t weight_in,
  input  logic              weight_shift,
  output conv_pkg::weight_t weight_out,
  input  conv_pkg::ifmap_t  ifmap_in,
  output conv_pkg::ifmap_t  ifmap_out,
  input  conv_pkg::ofmap_t  psum_in,
  output conv_pkg::ofmap_t  psum_out
);

  conv_pkg::weight_t weight_q;
  conv_pkg::ofmap_t  product;

  assign product    = weight_q * ifmap_in;  // signed, at sum width
  assign weight_out = weight_q;             // old weight goes down the chain

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight_q  <= '0;
      ifmap_out <= '0;
      psum_out  <= '0;
    end else begin
      if (weight_shift)
        weight_q <= weight_in;
      ifmap_out <= ifmap_in;
      psum_out  <= psum_in + product;
    end
  end

endmodule

/* source/systolic_array.sv */
`include "conv_params.svh"

module systolic_array (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    row_shift,
  input  conv_pkg::weight_t [`CONV_ARRAY_DIM-1:0] row_vec,
  input  conv_pkg::ifmap_vec_t                    ifmap_vec,
  input  logic                                    issue,
  output conv_pkg::ofmap_vec_t                    psum_vec,
  output logic                                    result_vld,
  output logic                                    array_busy
);

  localparam int D = `CONV_ARRAY_DIM;

  conv_pkg::weight_t w_link [D+1][D];  // down the columns
  conv_pkg::ifmap_t  x_link [D][D+1];  // across the rows
  conv_pkg::ofmap_t  p_link [D+1][D];  // partial sums, downward
  logic [2*D-1:0]    vld_sr;

  for (genvar k = 0; k < D; k++) begin : g_edge
    assign w_link[0][k] = row_vec[k];
    assign x_link[k][0] = ifmap_vec[k];
    assign p_link[0][k] = '0;
  end

  for (genvar r = 0; r < D; r++) begin : g_row
    for (genvar c = 0; c < D; c++) begin : g_col
      mac_pe pe_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .weight_in    (w_link[r][c]),
        .weight_shift (row_shift),
        .weight_out   (w_link[r+1][c]),
        .ifmap_in     (x_link[r][c]),
        .ifmap_out    (x_link[r][c+1]),
        .psum_in      (p_link[r][c]),
        .psum_out     (p_link[r+1][c])
      );
    end
  end

  // bottom row sums, one more stage so issue to result_vld is 2*D
  always_ff @(posedge clk) begin
    for (int k = 0; k < D; k++)
      psum_vec[k] <= p_link[D][k];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      vld_sr <= '0;
    else
      vld_sr <= {vld_sr[2*D-2:0], issue};
  end

  assign result_vld = vld_sr[2*D-1];
  assign array_busy = |vld_sr;

endmodule

/* source/ofmap_drain.sv */
`include "conv_params.svh"

module ofmap_drain (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 result_vld,
  input  conv_pkg::ofmap_vec_t result_vec,
  input  logic                 issue,
  output logic                 credit_ok,
  output conv_pkg::ofmap_t     ofmap_dat,
  output logic                 ofmap_vld,
  input  logic                 ofmap_rdy
);

  localparam int D     = `CONV_ARRAY_DIM;
  localparam int DEPTH = `CONV_FIFO_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  conv_pkg::ofmap_vec_t mem [DEPTH];
  logic [PW-1:0]        wr_ptr;
  logic [PW-1:0]        rd_ptr;
  logic [CW-1:0]        fill;     // vectors held
  logic [CW-1:0]        credits;  // in flight plus held
  logic [$clog2(D)-1:0] word;
  logic                 xfer;
  logic                 last_word;

  assign ofmap_vld = (fill != '0);
  assign ofmap_dat = mem[rd_ptr][word];
  assign xfer      = ofmap_vld & ofmap_rdy;
  assign last_word = xfer && (word == D - 1);
  assign credit_ok = (credits < CW'(DEPTH));

  always_ff @(posedge clk) begin
    if (result_vld)
      mem[wr_ptr] <= result_vec;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      credits <= '0;
      word    <= '0;
    end else begin
      if (result_vld)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (xfer)
        word <= (word == D - 1) ? '0 : word + 1'b1;  // channel 0 first
      if (last_word)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      fill    <= fill + CW'(result_vld) - CW'(last_word);
      credits <= credits + CW'(issue) - CW'(last_word);
    end
  end

  // credits must keep the FIFO from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    result_vld |-> (fill != CW'(DEPTH)));

  a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    ofmap_vld && !ofmap_rdy |=> ofmap_vld && $stable(ofmap_dat));

endmodule

/* source/conv_core.sv */
`include "conv_params.svh"

module conv_core (
  input  logic              clk,
  input  logic              rst_n,
  input  conv_pkg::ifmap_t  ifmap_dat,
  input  logic              ifmap_vld,
  output logic              ifmap_rdy,
  input  conv_pkg::weight_t weights_dat,
  input  logic              weights_vld,
  output logic              weights_rdy,
  output conv_pkg::ofmap_t  ofmap_dat,
  output logic              ofmap_vld,
  input  logic              ofmap_rdy
);

  logic                                    weights_loaded;
  logic                                    credit_ok;
  logic                                    issue;
  logic                                    row_shift;
  logic                                    array_busy;
  logic                                    result_vld;
  conv_pkg::weight_t [`CONV_ARRAY_DIM-1:0] row_vec;
  conv_pkg::ifmap_vec_t                    issue_vec;
  conv_pkg::ifmap_vec_t                    skewed_vec;
  conv_pkg::ofmap_vec_t                    psum_vec;
  conv_pkg::ofmap_vec_t                    result_vec;

  ifmap_packer ifmap_packer_i (
    .clk, .rst_n, .ifmap_dat, .ifmap_vld, .ifmap_rdy,
    .weights_loaded, .credit_ok, .issue, .issue_vec
  );

  weight_loader weight_loader_i (
    .clk, .rst_n, .weights_dat, .weights_vld, .weights_rdy,
    .array_busy, .row_shift, .row_vec, .weights_loaded
  );

  skew_delay #(
    .LANES   (`CONV_ARRAY_DIM),
    .WIDTH   (`CONV_IFMAP_W),
    .REVERSE (1'b0)
  ) in_skew_i (
    .clk, .rst_n, .in_vec(issue_vec), .out_vec(skewed_vec)
  );

  systolic_array systolic_array_i (
    .clk, .rst_n, .row_shift, .row_vec, .ifmap_vec(skewed_vec),
    .issue, .psum_vec, .result_vld, .array_busy
  );

  // lane o waits D-1-o cycles so all sums line up
  skew_delay #(
    .LANES   (`CONV_ARRAY_DIM),
    .WIDTH   (`CONV_OFMAP_W),
    .REVERSE (1'b1)
  ) out_deskew_i (
    .clk, .rst_n, .in_vec(psum_vec), .out_vec(result_vec)
  );

  ofmap_drain ofmap_drain_i (
    .clk, .rst_n, .result_vld, .result_vec, .issue,
    .credit_ok, .ofmap_dat, .ofmap_vld, .ofmap_rdy
  );

endmodule

/* bench/tb_clock.sv */
module tb_clock (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  initial begin
    rst_n = 1'b0;
    repeat (2) @(negedge clk);  // rising edges at 5 and 15 see reset
    rst_n = 1'b1;
  end

endmodule

/* bench/conv_checker.sv */
`include "conv_params.svh"

module conv_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  conv_pkg::weight_t weights_dat,
  input  logic              weights_vld,
  input  logic              weights_rdy,
  input  conv_pkg::ifmap_t  ifmap_dat,
  input  logic              ifmap_vld,
  input  logic              ifmap_rdy,
  input  conv_pkg::ofmap_t  ofmap_dat,
  input  logic              ofmap_vld,
  input  logic              ofmap_rdy,
  input  logic              test_end,
  output int                pending,
  output int                errors
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int D = `CONV_ARRAY_DIM;

  conv_pkg::weight_t w_model [D][D];  // [input channel][output channel]
  conv_pkg::ifmap_t  x_buf [D];
  conv_pkg::ofmap_t  expect_q [$];
  conv_pkg::ofmap_t  exp_word;
  int                w_word;  // position in the current weight set
  int                x_lane;
  int                acc;
  int                test_num;
  int                test_start;
  logic              loaded;
  logic              first;

  task automatic expect_level(input string name, input logic actual, input logic want);
    if (actual !== want) begin
      $display("Fail %s: expected %h, got %h", name, want, actual);
      errors++;
    end
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_word     = 0;
      x_lane     = 0;
      test_num   = 0;
      test_start = 0;
      errors     = 0;
      loaded     = 1'b0;
      first      = 1'b1;
      expect_q.delete();
    end else begin
      if (first) begin
        expect_level("ifmap_rdy", ifmap_rdy, 1'b0);
        expect_level("ofmap_vld", ofmap_vld, 1'b0);
        expect_level("weights_rdy", weights_rdy, 1'b1);
        first = 1'b0;
      end
      if (ifmap_rdy && !loaded) begin
        $display("ifmap_rdy is high without a complete weight set");
        errors++;
      end
      if (weights_vld && weights_rdy) begin
        // k-th row of a set is input channel D-1-k
        w_model[D - 1 - w_word / D][w_word % D] = weights_dat;
        w_word = (w_word + 1) % (D * D);
        loaded = (w_word == 0);
      end
      if (ifmap_vld && ifmap_rdy) begin
        x_buf[x_lane] = ifmap_dat;
        x_lane = (x_lane + 1) % D;
        if (x_lane == 0) begin
          for (int o = 0; o < D; o++) begin
            acc = 0;
            for (int i = 0; i < D; i++)
              acc += int'(w_model[i][o]) * int'(x_buf[i]);  // wraps at 32 bits
            expect_q.push_back(conv_pkg::ofmap_t'(acc));
          end
        end
      end
      if (ofmap_vld && ofmap_rdy) begin
        if (expect_q.size() == 0) begin
          $display("ofmap word %h came out with no result pending", ofmap_dat);
          errors++;
        end else begin
          exp_word = expect_q.pop_front();
          if (ofmap_dat !== exp_word) begin
            $display("Fail ofmap_dat: expected %h, got %h", exp_word, ofmap_dat);
            errors++;
          end
        end
      end
      if (test_end) begin
        if (expect_q.size() != 0) begin
          $display("%0d result words never came out", expect_q.size());
          errors++;
          expect_q.delete();
        end
        expect_level("weights_rdy", weights_rdy, 1'b1);  // array drained
        test_num++;
        $display("test %0d done, %0d errors", test_num, errors - test_start);
        test_start = errors;
      end
    end
    pending = expect_q.size();
  end

endmodule

/* bench/conv_core_tb.sv */
`include "conv_params.svh"

module conv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int D      = `CONV_ARRAY_DIM;
  localparam int N_LONG = 64;
  localparam int N_BP   = 48;
  localparam int N_NEW  = 24;
  // all weight, ifmap and ofmap words, four cycles each under back-pressure
  localparam int LIMIT  = 4 * (3 * D * D + 2 * D * (1 + N_LONG + N_BP + N_NEW)) + 500;

  logic              clk;
  logic              rst_n;
  conv_pkg::ifmap_t  ifmap_dat;
  logic              ifmap_vld;
  logic              ifmap_rdy;
  conv_pkg::weight_t weights_dat;
  logic              weights_vld;
  logic              weights_rdy;
  conv_pkg::ofmap_t  ofmap_dat;
  logic              ofmap_vld;
  logic              ofmap_rdy = 1'b1;
  logic              test_end;
  int                pending;
  int                errors;
  int                seed = 32'hb7d0fcba;
  int                cycles = 0;
  logic              bp_on = 1'b0;
  logic [255:0]      bp_bits;

  tb_clock tb_clock_i (.*);
  conv_core conv_core_i (.*);
  conv_checker conv_checker_i (.*);

  always @(negedge clk)
    ofmap_rdy = bp_on ? bp_bits[cycles % 256] : 1'b1;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout, run stopped after %0d cycles", LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // rows go out for input channel D-1 first
  task automatic load_weights(input bit identity);
    logic taken;
    for (int k = 0; k < D * D; k++) begin
      if (identity)
        weights_dat = conv_pkg::weight_t'(D - 1 - k / D == k % D);
      else
        weights_dat = conv_pkg::weight_t'($random(seed));
      weights_vld = 1'b1;
      taken = 1'b0;
      while (!taken) begin
        taken = weights_rdy;  // moves on the coming rising edge
        @(negedge clk);
      end
      weights_vld = 1'b0;
    end
  endtask

  task automatic send_vectors(input int n);
    logic taken;
    for (int v = 0; v < n * D; v++) begin
      if (($random(seed) & 3) == 0)
        @(negedge clk);  // idle gap
      ifmap_dat = conv_pkg::ifmap_t'($random(seed));
      ifmap_vld = 1'b1;
      taken = 1'b0;
      while (!taken) begin
        taken = ifmap_rdy;
        @(negedge clk);
      end
      ifmap_vld = 1'b0;
    end
  endtask

  task automatic close_test();
    int n;
    n = 0;
    while (pending != 0 && n < 200) begin
      @(negedge clk);
      n++;
    end
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    ifmap_dat   = '0;
    ifmap_vld   = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    test_end    = 1'b0;
    for (int i = 0; i < 8; i++)
      bp_bits[32*i +: 32] = $random(seed);
    @(posedge rst_n);
    @(negedge clk);

    load_weights(1'b1);  // ifmap_rdy watched low through the load
    while (!ifmap_rdy)
      @(negedge clk);
    close_test();
    send_vectors(1);
    close_test();
    load_weights(1'b0);
    send_vectors(N_LONG);
    close_test();
    bp_on = 1'b1;
    send_vectors(N_BP);
    close_test();
    bp_on = 1'b0;
    load_weights(1'b0);  // fresh set for the last stream
    send_vectors(N_NEW);
    close_test();

    $display("5 tests run, %0d errors", errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+source
source/conv_pkg.sv
source/ifmap_packer.sv
source/weight_loader.sv
source/skew_delay.sv
source/mac_pe.sv
source/systolic_array.sv
source/ofmap_drain.sv
source/conv_core.sv
bench/tb_clock.sv
bench/conv_checker.sv
bench/conv_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run, then search the log for the failure line
verilator --binary --timing --assert -Wno-fatal --top-module conv_core_tb -f verilog.f \
  && ./obj_dir/Vconv_core_tb > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "=== FAIL ===" sim.log \
  || { echo "simulation failed, see sim.log"; exit 1; }
